//--- tests/exec_input.txt
// Columns: instr(32) _ reg to inspect(8) _ expected value(32) _ flags(4)
// Flags: bit3 busy after issue, bit2 issue back-to-back, bit1 trap, bit0 illegal
20010005_01_00000005_0
2002FFFD_02_FFFFFFFD_0
20000007_00_00000000_0
20037FFF_03_00007FFF_0
00222020_04_00000002_0
00222822_05_00000008_0
00233024_06_00000005_0
00433825_07_FFFFFFFF_0
00234026_08_00007FFA_0
00234827_09_FFFF8000_0
0041502A_0A_00000001_0
0022582A_0B_00000000_0
00036100_0C_0007FFF0_0
00026F02_0D_0000000F_0
00027043_0E_FFFFFFFE_0
200F0064_0F_00000064_0
01EF8020_10_000000C8_4
2011FFFF_11_FFFFFFFF_0
20128001_12_FFFF8001_0
02320019_11_FFFFFFFF_8
00009810_13_FFFF8000_0
0000A012_14_00007FFF_0
0021A834_15_00000000_2
00220034_01_00000005_0
0022A836_15_00000000_2
00210036_02_FFFFFFFD_0
0022B001_16_00000000_1
3C170001_17_00000000_1

//--- compile.f
rtl/exec_pkg.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/mul_unit.sv
rtl/exec_core.sv
rtl/exec_top.sv
tests/exec_assertions.sv
tests/exec_tb.sv

//--- Bender.yml
package:
  name: exec_engine

sources:
  - rtl/exec_pkg.sv
  - rtl/instr_decoder.sv
  - rtl/alu.sv
  - rtl/reg_file.sv
  - rtl/mul_unit.sv
  - rtl/exec_core.sv
  - rtl/exec_top.sv
  - target: test
    files:
      - tests/exec_assertions.sv
      - tests/exec_tb.sv

//--- tests/exec_tb.sv
`default_nettype none

module exec_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_lines    = 64;
    localparam int reset_cycles = 10;

    logic        clk;
    logic        rst;
    logic        instr_valid;
    logic [31:0] instr;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;
    logic        busy;
    logic        trap;
    logic        illegal;

    // instr [75:44], reg [43:36], expected [35:4], flags [3:0]
    logic [75:0] lines [max_lines];
    int          line_errors [max_lines];
    int          n_lines;
    int          cycles         = 0;
    int          timeout_cycles = 100000;
    int          tests_run      = 0;
    int          tests_failed   = 0;

    exec_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .dbg_addr    (dbg_addr),
        .dbg_data    (dbg_data),
        .busy        (busy),
        .trap        (trap),
        .illegal     (illegal)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;  // 100 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the DUT stayed busy too long", cycles);
            $display("sim failed");
            $finish;
        end
    end

    task automatic report_test(input int num, input logic [31:0] word, input int errs);
        tests_run++;
        if (errs != 0)
            tests_failed++;
        $display("test %0d instr %h: %s", num, word, (errs == 0) ? "ok" : "mismatch");
    endtask

    // Returns 1 on a mismatch
    function automatic int compare_bit(input string name, input logic got, input logic exp);
        int bad;
        bad = 0;
        assert (got === exp) else begin
            $display("ERROR %0t %s expected %b got %b", $time, name, exp, got);
            bad = 1;
        end
        return bad;
    endfunction

    // Flags: bit 3 busy, bit 2 chained issue, bit 1 trap, bit 0 illegal
    task automatic check_flags(input int idx);
        line_errors[idx] += compare_bit("trap", trap, lines[idx][1]);
        line_errors[idx] += compare_bit("illegal", illegal, lines[idx][0]);
        line_errors[idx] += compare_bit("busy", busy, lines[idx][3]);
    endtask

    task automatic check_reg(input int idx);
        logic [31:0] exp;
        exp = lines[idx][35:4];
        assert (dbg_data === exp) else begin
            $display("ERROR %0t dbg_data r%0d expected %h got %h",
                     $time, dbg_addr, exp, dbg_data);
            line_errors[idx]++;
        end
        report_test(idx + 1, lines[idx][75:44], line_errors[idx]);
    endtask

    task automatic check_reset_state();
        int errs;
        errs = 0;
        errs += compare_bit("busy", busy, 1'b0);
        errs += compare_bit("trap", trap, 1'b0);
        errs += compare_bit("illegal", illegal, 1'b0);
        for (int r = 0; r < 32; r++) begin
            dbg_addr = 5'(r);
            @(negedge clk);
            assert (dbg_data === 32'h0) else begin
                $display("ERROR %0t dbg_data r%0d expected %h got %h",
                         $time, r, 32'h0, dbg_data);
                errs++;
            end
        end
        report_test(0, 32'h0, errs);
    endtask

    initial begin
        int   idx;
        logic chain;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_addr    = '0;
        for (int i = 0; i < max_lines; i++)
            line_errors[i] = 0;
        $readmemh("tests/exec_input.txt", lines);
        n_lines = 0;
        while (n_lines < max_lines && !$isunknown(lines[n_lines]))
            n_lines++;
        timeout_cycles = n_lines * 40 + reset_cycles + 32 + 100;
        assert (n_lines > 0) else begin
            $display("No test lines could be read from tests/exec_input.txt");
            tests_failed++;
        end

        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        check_reset_state();

        idx = 0;
        while (idx < n_lines) begin
            while (busy)
                @(negedge clk);
            chain       = (idx + 1 < n_lines) && lines[idx + 1][2];
            instr       = lines[idx][75:44];
            dbg_addr    = lines[idx][40:36];
            instr_valid = 1'b1;
            @(negedge clk);
            check_flags(idx);
            if (chain) begin
                instr = lines[idx + 1][75:44];  // Accepted on the very next edge
                @(negedge clk);
                check_flags(idx + 1);
            end
            instr_valid = 1'b0;
            if (!chain)
                @(negedge clk);
            check_reg(idx);
            if (chain) begin
                dbg_addr = lines[idx + 1][40:36];
                @(negedge clk);
                check_reg(idx + 1);
                idx++;
            end
            idx++;
        end

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/exec_assertions.sv
`default_nettype none

module exec_assertions (
    input logic                clk,
    input logic                rst,
    input logic                busy,
    input logic                trap,
    input logic                illegal,
    input logic                mul_busy,
    input exec_pkg::rf_write_t wr
);

    timeunit 1ns;
    timeprecision 1ps;

    trap_illegal_excl: assert property (@(posedge clk) disable iff (rst) !(trap && illegal))
        else $error("trap and illegal high in the same cycle");

    trap_pulse: assert property (@(posedge clk) disable iff (rst) trap |=> !trap)
        else $error("trap held longer than one cycle");

    illegal_pulse: assert property (@(posedge clk) disable iff (rst) illegal |=> !illegal)
        else $error("illegal held longer than one cycle");

    // HI/LO results only reach the file through MFHI/MFLO
    no_write_in_mul: assert property (@(posedge clk) disable iff (rst) mul_busy |-> !wr.en)
        else $error("register write enabled while the multiplier is busy");

    idle_after_reset: assert property (@(posedge clk) $fell(rst) |-> !busy)
        else $error("busy high right after reset");

endmodule

bind exec_core exec_assertions u_assert (
    .clk      (clk),
    .rst      (rst),
    .busy     (busy),
    .trap     (trap),
    .illegal  (illegal),
    .mul_busy (mul_busy),
    .wr       (wr)
);

`default_nettype wire

//--- rtl/exec_top.sv
`default_nettype none

module exec_top #(
    parameter int data_w = exec_pkg::DATA_W
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,
    input  logic [31:0]       instr,
    input  logic [4:0]        dbg_addr,
    output logic [data_w-1:0] dbg_data,
    output logic              busy,
    output logic              trap,
    output logic              illegal
);

    logic [4:0]          rs_addr;
    logic [4:0]          rt_addr;
    logic [data_w-1:0]   rs_data;
    logic [data_w-1:0]   rt_data;
    exec_pkg::rf_write_t wr;
    logic                mul_start;
    logic [data_w-1:0]   mul_a;
    logic [data_w-1:0]   mul_b;
    logic                mul_busy;
    logic [data_w-1:0]   hi;
    logic [data_w-1:0]   lo;

    exec_core #(.data_w(data_w)) u_core (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .wr          (wr),
        .mul_start   (mul_start),
        .mul_a       (mul_a),
        .mul_b       (mul_b),
        .mul_busy    (mul_busy),
        .hi          (hi),
        .lo          (lo),
        .busy        (busy),
        .trap        (trap),
        .illegal     (illegal)
    );

    reg_file #(.data_w(data_w)) u_rf (
        .clk      (clk),
        .rst      (rst),
        .ra1      (rs_addr),
        .ra2      (rt_addr),
        .dbg_addr (dbg_addr),
        .wr       (wr),
        .rd1      (rs_data),
        .rd2      (rt_data),
        .dbg_data (dbg_data)
    );

    mul_unit #(.data_w(data_w)) u_mul (
        .clk   (clk),
        .rst   (rst),
        .start (mul_start),
        .a     (mul_a),
        .b     (mul_b),
        .busy  (mul_busy),
        .hi    (hi),
        .lo    (lo)
    );

endmodule

`default_nettype wire

//--- rtl/exec_core.sv
`default_nettype none

module exec_core #(
    parameter int data_w = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                instr_valid,
    input  logic [31:0]         instr,
    output logic [4:0]          rs_addr,
    output logic [4:0]          rt_addr,
    input  logic [data_w-1:0]   rs_data,
    input  logic [data_w-1:0]   rt_data,
    output exec_pkg::rf_write_t wr,
    output logic                mul_start,
    output logic [data_w-1:0]   mul_a,
    output logic [data_w-1:0]   mul_b,
    input  logic                mul_busy,
    input  logic [data_w-1:0]   hi,
    input  logic [data_w-1:0]   lo,
    output logic                busy,
    output logic                trap,
    output logic                illegal
);

    exec_pkg::ctrl_t              ctrl;
    logic                         accept;
    logic [data_w-1:0]            op_a;
    logic [data_w-1:0]            rt_fwd;
    logic [data_w-1:0]            imm_ext;
    logic [data_w-1:0]            op_b;
    logic [data_w-1:0]            alu_y;
    logic [data_w-1:0]            wb_data;
    logic [exec_pkg::DATA_W-1:0]  wb_ext;
    logic                         equal;
    logic                         trap_hit;

    instr_decoder u_dec (
        .instr (instr),
        .ctrl  (ctrl)
    );

    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];

    // Pending write is not yet in the register file, bypass it
    assign op_a   = (wr.en && wr.addr == rs_addr && rs_addr != 5'd0) ?
                    wr.data[data_w-1:0] : rs_data;
    assign rt_fwd = (wr.en && wr.addr == rt_addr && rt_addr != 5'd0) ?
                    wr.data[data_w-1:0] : rt_data;

    assign imm_ext = data_w'($signed(instr[15:0]));
    assign op_b    = ctrl.use_imm ? imm_ext : rt_fwd;

    alu #(.data_w(data_w)) u_alu (
        .op    (ctrl.alu_op),
        .a     (op_a),
        .b     (op_b),
        .shamt (instr[10:6]),
        .y     (alu_y),
        .equal (equal)
    );

    assign accept    = instr_valid && !mul_busy;
    assign mul_start = accept && ctrl.start_mul;
    assign mul_a     = op_a;
    assign mul_b     = rt_fwd;
    assign busy      = mul_busy || mul_start;  // Covers the start cycle too

    always_comb begin
        case (ctrl.wb_src)
            exec_pkg::WB_HI: wb_data = hi;
            exec_pkg::WB_LO: wb_data = lo;
            default:         wb_data = alu_y;
        endcase
    end

    always_comb begin
        wb_ext               = '0;
        wb_ext[data_w-1:0]   = wb_data;
    end

    assign trap_hit = (ctrl.trap_eq && equal) || (ctrl.trap_ne && !equal);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr      <= '0;
            trap    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            wr.en   <= accept && ctrl.wb_src != exec_pkg::WB_NONE;
            wr.addr <= ctrl.dest;
            wr.data <= wb_ext;
            trap    <= accept && trap_hit;      // One-cycle pulse
            illegal <= accept && ctrl.illegal;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mul_unit.sv
`default_nettype none

module mul_unit #(
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic              busy,
    output logic [data_w-1:0] hi,
    output logic [data_w-1:0] lo
);

    localparam int cnt_w = $clog2(data_w + 1);

    logic [data_w-1:0]   mcand;
    logic [2*data_w-1:0] prod;   // {HI, LO}, low half starts as the multiplier
    logic [cnt_w-1:0]    count;
    logic [data_w-1:0]   addend;
    logic [data_w:0]     sum;    // Extra bit keeps the carry

    assign addend = prod[0] ? mcand : '0;
    assign sum    = {1'b0, prod[2*data_w-1:data_w]} + {1'b0, addend};

    always_ff @(posedge clk) begin
        if (start)
            mcand <= a;
    end

    // One shift-add step per cycle, product shifts right into LO
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prod  <= '0;
            count <= '0;
        end else if (start) begin
            prod  <= {{data_w{1'b0}}, b};
            count <= cnt_w'(data_w);
        end else if (busy) begin
            prod  <= {sum, prod[data_w-1:1]};
            count <= count - cnt_w'(1);
        end
    end

    assign busy = (count != '0);
    assign hi   = prod[2*data_w-1:data_w];
    assign lo   = prod[data_w-1:0];

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`default_nettype none

module reg_file #(
    parameter int data_w = 32
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          ra1,
    input  logic [4:0]          ra2,
    input  logic [4:0]          dbg_addr,
    input  exec_pkg::rf_write_t wr,
    output logic [data_w-1:0]   rd1,
    output logic [data_w-1:0]   rd2,
    output logic [data_w-1:0]   dbg_data
);

    logic [data_w-1:0] regs [32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr.en && wr.addr != 5'd0) begin  // r0 stays zero
            regs[wr.addr] <= wr.data[data_w-1:0];
        end
    end

    assign rd1      = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2      = (ra2 == 5'd0) ? '0 : regs[ra2];
    assign dbg_data = (dbg_addr == 5'd0) ? '0 : regs[dbg_addr];

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu #(
    parameter int data_w = 32
) (
    input  exec_pkg::alu_op_e  op,
    input  logic [data_w-1:0]  a,
    input  logic [data_w-1:0]  b,
    input  logic [4:0]         shamt,
    output logic [data_w-1:0]  y,
    output logic               equal
);

    assign equal = (a == b);  // For TEQ/TNE

    always_comb begin
        case (op)
            exec_pkg::ALU_AND: y = a & b;
            exec_pkg::ALU_OR:  y = a | b;
            exec_pkg::ALU_ADD: y = a + b;
            exec_pkg::ALU_NOR: y = ~(a | b);
            exec_pkg::ALU_SLL: y = b << shamt;
            exec_pkg::ALU_SRL: y = b >> shamt;
            exec_pkg::ALU_SUB: y = a - b;
            // Signed compare, result is 0 or 1
            exec_pkg::ALU_SLT: y = data_w'($signed(a) < $signed(b));
            exec_pkg::ALU_SRA: y = $signed(b) >>> shamt;
            exec_pkg::ALU_XOR: y = a ^ b;
            default:           y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  logic [31:0]     instr,
    output exec_pkg::ctrl_t ctrl
);

    exec_pkg::opcode_e opcode;
    exec_pkg::funct_e  funct;

    assign opcode = exec_pkg::opcode_e'(instr[31:26]);
    assign funct  = exec_pkg::funct_e'(instr[5:0]);

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = exec_pkg::ALU_ADD;
        ctrl.wb_src = exec_pkg::WB_NONE;
        ctrl.dest   = instr[15:11];  // rd unless overridden
        case (opcode)
            exec_pkg::OP_RTYPE: begin
                ctrl.wb_src = exec_pkg::WB_ALU;
                case (funct)
                    exec_pkg::FN_ADD: ctrl.alu_op = exec_pkg::ALU_ADD;
                    exec_pkg::FN_SUB: ctrl.alu_op = exec_pkg::ALU_SUB;
                    exec_pkg::FN_AND: ctrl.alu_op = exec_pkg::ALU_AND;
                    exec_pkg::FN_OR:  ctrl.alu_op = exec_pkg::ALU_OR;
                    exec_pkg::FN_NOR: ctrl.alu_op = exec_pkg::ALU_NOR;
                    exec_pkg::FN_XOR: ctrl.alu_op = exec_pkg::ALU_XOR;
                    exec_pkg::FN_SLT: ctrl.alu_op = exec_pkg::ALU_SLT;
                    exec_pkg::FN_SLL: ctrl.alu_op = exec_pkg::ALU_SLL;
                    exec_pkg::FN_SRL: ctrl.alu_op = exec_pkg::ALU_SRL;
                    exec_pkg::FN_SRA: ctrl.alu_op = exec_pkg::ALU_SRA;
                    exec_pkg::FN_MULTU: begin
                        ctrl.wb_src    = exec_pkg::WB_NONE;  // Result lands in HI/LO
                        ctrl.start_mul = 1'b1;
                    end
                    exec_pkg::FN_MFHI: ctrl.wb_src = exec_pkg::WB_HI;
                    exec_pkg::FN_MFLO: ctrl.wb_src = exec_pkg::WB_LO;
                    exec_pkg::FN_TEQ: begin
                        ctrl.wb_src  = exec_pkg::WB_NONE;
                        ctrl.trap_eq = 1'b1;
                    end
                    exec_pkg::FN_TNE: begin
                        ctrl.wb_src  = exec_pkg::WB_NONE;
                        ctrl.trap_ne = 1'b1;
                    end
                    default: begin
                        ctrl.wb_src  = exec_pkg::WB_NONE;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            exec_pkg::OP_ADDI: begin
                ctrl.wb_src  = exec_pkg::WB_ALU;
                ctrl.use_imm = 1'b1;
                ctrl.dest    = instr[20:16];  // rt for I-type
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int DATA_W = 32;  // Widest datapath the write struct must carry

    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_ADDI  = 6'd8
    } opcode_e;

    // R-type function field, MIPS encodings
    typedef enum logic [5:0] {
        FN_SLL   = 6'd0,
        FN_SRL   = 6'd2,
        FN_SRA   = 6'd3,
        FN_MFHI  = 6'd16,
        FN_MFLO  = 6'd18,
        FN_MULTU = 6'd25,
        FN_ADD   = 6'd32,
        FN_SUB   = 6'd34,
        FN_AND   = 6'd36,
        FN_OR    = 6'd37,
        FN_XOR   = 6'd38,
        FN_NOR   = 6'd39,
        FN_SLT   = 6'd42,
        FN_TEQ   = 6'd52,
        FN_TNE   = 6'd54
    } funct_e;

    typedef enum logic [3:0] {
        ALU_AND = 4'd0,
        ALU_OR  = 4'd1,
        ALU_ADD = 4'd2,
        ALU_NOR = 4'd3,
        ALU_SLL = 4'd4,
        ALU_SRL = 4'd5,
        ALU_SUB = 4'd6,
        ALU_SLT = 4'd7,
        ALU_SRA = 4'd8,
        ALU_XOR = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_HI   = 2'd1,
        WB_LO   = 2'd2,
        WB_NONE = 2'd3
    } wb_src_e;

    typedef struct packed {
        alu_op_e    alu_op;
        wb_src_e    wb_src;
        logic       use_imm;   // Operand B from sign-extended immediate
        logic [4:0] dest;
        logic       start_mul;
        logic       trap_eq;
        logic       trap_ne;
        logic       illegal;
    } ctrl_t;

    typedef struct packed {
        logic              en;
        logic [4:0]        addr;
        logic [DATA_W-1:0] data;
    } rf_write_t;

endpackage

`default_nettype wire
